// File: hdl/jsp_pkg.sv
////////////////////////////////////////
// Widths, types and FSM states of the JTAG serial port
// Imported by wildcard into every RTL module of the port
////////////////////////////////////////
package jsp_pkg;

  ////////////////////////////////////////
  // Sizes
  localparam int JSP_FIFO_DEPTH = 8;                     // Bytes held by each FIFO
  localparam int JSP_BYTE_BITS  = 8;                     // Bits per shifted byte
  localparam int JSP_PTR_BITS   = $clog2(JSP_FIFO_DEPTH); // FIFO pointer width

  ////////////////////////////////////////
  // Data types
  typedef logic [3:0] jsp_count_t;                 // Byte count 0..8, or bit index
  typedef logic [JSP_BYTE_BITS-1:0] jsp_byte_t;    // One data byte

  // Two count nibbles packed into one byte
  typedef struct packed {
    jsp_count_t hi;  // Header user count, or status bytes available
    jsp_count_t lo;  // Status free space, ignored in a header
  } jsp_nibbles_t;

  // A shifted byte is either payload or a header/status word
  typedef union packed {
    jsp_byte_t    data;
    jsp_nibbles_t nib;
  } jsp_word_u;

  // Byte stream, ready runs the other way
  typedef struct packed {
    logic      valid;
    jsp_byte_t data;
  } jsp_stream_t;

  // TAP state as decoded for this data register
  typedef struct packed {
    logic capture;  // Capture-DR
    logic shift;    // Shift-DR
    logic update;   // Update-DR
    logic select;   // Our register is in the chain
  } jsp_tap_t;

  ////////////////////////////////////////
  // FSM states
  typedef enum logic [1:0] {RX_IDLE, RX_WAIT, RX_COUNTS, RX_XFER} jsp_rx_state_e;
  typedef enum logic [1:0] {TX_IDLE, TX_COUNTS, TX_RDACK, TX_XFER} jsp_tx_state_e;

endpackage

// File: hdl/jsp_byte_fifo.sv
////////////////////////////////////////
// Byte FIFO with valid/ready on both ports
// Also reports its occupancy for the status byte
////////////////////////////////////////
`timescale 1ns/1ps

module jsp_byte_fifo
  import jsp_pkg::*;
(
  input  logic        tck_i,
  input  logic        rst_i,
  input  jsp_stream_t wr_i,        // Write side
  output logic        wr_ready_o,  // Low when full
  output jsp_stream_t rd_o,        // Head of queue
  input  logic        rd_ready_i,  // Pop request
  output jsp_count_t  count_o      // Bytes stored
);

  jsp_byte_t               mem_q [JSP_FIFO_DEPTH];  // Storage
  logic [JSP_PTR_BITS-1:0] wr_ptr_q;                // Next free slot
  logic [JSP_PTR_BITS-1:0] rd_ptr_q;                // Oldest byte
  jsp_count_t              count_q;                 // Occupancy
  logic                    full;
  logic                    empty;
  logic                    push;
  logic                    pop;

  assign full  = (count_q == jsp_count_t'(JSP_FIFO_DEPTH));
  assign empty = (count_q == '0);
  assign push  = wr_i.valid && !full;  // Write refused when full
  assign pop   = rd_ready_i && !empty;

  // Storage
  always_ff @(posedge tck_i) begin
    if (push) mem_q[wr_ptr_q] <= wr_i.data;
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;                           // Both or neither, count holds
      endcase
    end
  end

  assign wr_ready_o = !full;
  assign rd_o.valid = !empty;
  assign rd_o.data  = mem_q[rd_ptr_q];  // Head visible one cycle after push
  assign count_o    = count_q;

endmodule

// File: hdl/jsp_rx_ctrl.sv
////////////////////////////////////////
// Write path, host to system
// Waits for a start bit, decodes the header and pushes data bytes
////////////////////////////////////////
`timescale 1ns/1ps

module jsp_rx_ctrl
  import jsp_pkg::*;
(
  input  logic        tck_i,
  input  logic        rst_i,
  input  logic        tdi_i,       // Serial data from the host
  input  jsp_tap_t    tap_i,
  input  jsp_count_t  rx_count_i,  // Bytes sitting in the rx FIFO
  output jsp_stream_t push_o       // One strobe per accepted byte
);

  jsp_rx_state_e state_q;
  jsp_rx_state_e state_d;
  jsp_count_t    bit_cnt_q;  // Bits taken into the current byte
  jsp_count_t    space_q;    // Free rx FIFO bytes as sampled at capture
  jsp_count_t    user_q;     // Bytes the host still means to send
  jsp_byte_t     shift_q;    // Receive shift register filled LSB first
  jsp_word_u     word;       // Byte as it stands after this shift edge
  logic          start;
  logic          shift_en;
  logic          bit_last;
  logic          hdr_done;
  logic          accept;

  ////////////////////////////////////////
  // Decode

  // Incoming bit enters at the top, so the first bit ends up as bit 0
  always_comb begin
    word.data = {tdi_i, shift_q[JSP_BYTE_BITS-1:1]};
  end

  assign start    = (state_q == RX_IDLE) && tap_i.select && tap_i.capture;
  assign shift_en = tap_i.shift && ((state_q == RX_COUNTS) || (state_q == RX_XFER));
  assign bit_last = (bit_cnt_q == jsp_count_t'(JSP_BYTE_BITS - 1));
  assign hdr_done = shift_en && bit_last && (state_q == RX_COUNTS);

  // A data byte only goes through while both budgets last
  assign accept = shift_en && bit_last && (state_q == RX_XFER)
                  && (space_q != '0) && (user_q != '0);

  ////////////////////////////////////////
  // FSM

  always_comb begin
    state_d = state_q;
    case (state_q)
      RX_IDLE: begin
        if (tap_i.select && tap_i.capture) state_d = RX_WAIT;
      end
      RX_WAIT: begin
        if (tap_i.update)                state_d = RX_IDLE;
        else if (tap_i.shift && tdi_i)   state_d = RX_COUNTS;  // Start bit seen
      end
      RX_COUNTS: begin
        if (tap_i.update)                state_d = RX_IDLE;
        else if (hdr_done)               state_d = RX_XFER;    // Header complete
      end
      RX_XFER: begin
        if (tap_i.update)                state_d = RX_IDLE;
      end
      default: state_d = RX_IDLE;
    endcase
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= RX_IDLE;
      bit_cnt_q <= '0;
      space_q   <= '0;
      user_q    <= '0;
    end else begin
      state_q <= state_d;

      // Bit counter restarts at capture and after every byte
      if (start)
        bit_cnt_q <= '0;
      else if (shift_en)
        bit_cnt_q <= bit_last ? '0 : bit_cnt_q + 1'b1;

      // Space budget
      if (start)
        space_q <= jsp_count_t'(JSP_FIFO_DEPTH) - rx_count_i;
      else if (accept)
        space_q <= space_q - 1'b1;

      // User budget from the header hi nibble
      if (hdr_done)
        user_q <= word.nib.hi;
      else if (accept)
        user_q <= user_q - 1'b1;
    end
  end

  // Header and data bits both pass through here
  always_ff @(posedge tck_i) begin
    if (shift_en) shift_q <= word.data;
  end

  assign push_o.valid = accept;     // FIFO has room by construction
  assign push_o.data  = word.data;

endmodule

// File: hdl/jsp_tx_ctrl.sv
////////////////////////////////////////
// Read path, system to host
// Sends the status byte, then the queued bytes on TDO
////////////////////////////////////////
`timescale 1ns/1ps

module jsp_tx_ctrl
  import jsp_pkg::*;
(
  input  logic        tck_i,
  input  logic        rst_i,
  input  jsp_tap_t    tap_i,
  input  jsp_count_t  rx_count_i,  // Occupancy of the rx FIFO
  input  jsp_count_t  tx_count_i,  // Occupancy of the tx FIFO
  input  jsp_stream_t head_i,      // Head of the tx FIFO
  output logic        pop_o,       // Acknowledge the head byte
  output logic        tdo_o
);

  jsp_tx_state_e state_q;
  jsp_tx_state_e state_d;
  jsp_count_t    bit_cnt_q;  // Bits sent from the current byte
  jsp_count_t    out_cnt_q;  // Bytes still to hand to the host
  jsp_byte_t     out_q;      // Output shift register
  jsp_word_u     status;     // Status byte built at capture
  logic          start;
  logic          shift_en;
  logic          bit_last;
  logic          cnt_zero;
  logic          load_head;
  logic          xfer_dec;

  ////////////////////////////////////////
  // Status byte and decode

  always_comb begin
    status.nib.hi = tx_count_i;                                // Bytes waiting for the host
    status.nib.lo = jsp_count_t'(JSP_FIFO_DEPTH) - rx_count_i; // Room for host bytes
  end

  assign start    = (state_q == TX_IDLE) && tap_i.select && tap_i.capture;
  assign shift_en = tap_i.shift && (state_q != TX_IDLE);  // Pause and exit do nothing
  assign bit_last = (bit_cnt_q == jsp_count_t'(JSP_BYTE_BITS - 1));
  assign cnt_zero = (out_cnt_q == '0);

  // Next byte latched at the end of a byte and acknowledged one edge later
  assign load_head = shift_en && bit_last && !cnt_zero
                     && ((state_q == TX_COUNTS) || (state_q == TX_XFER));
  assign xfer_dec  = load_head && (state_q == TX_XFER);

  // No pop once the byte budget is spent
  assign pop_o = shift_en && (state_q == TX_RDACK) && !cnt_zero && head_i.valid;

  ////////////////////////////////////////
  // FSM

  always_comb begin
    state_d = state_q;
    case (state_q)
      TX_IDLE: begin
        if (tap_i.select && tap_i.capture) state_d = TX_COUNTS;
      end
      TX_COUNTS: begin
        if (tap_i.update)                  state_d = TX_IDLE;
        else if (shift_en && bit_last)     state_d = TX_RDACK;  // Status byte out
      end
      TX_RDACK: begin
        if (tap_i.update)                  state_d = TX_IDLE;
        else if (shift_en)                 state_d = TX_XFER;   // One edge only
      end
      TX_XFER: begin
        if (tap_i.update)                  state_d = TX_IDLE;
        else if (shift_en && bit_last)     state_d = TX_RDACK;
      end
      default: state_d = TX_IDLE;
    endcase
  end

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state_q   <= TX_IDLE;
      bit_cnt_q <= '0;
      out_cnt_q <= '0;
      out_q     <= '0;  // TDO idles low until the first capture
    end else begin
      state_q <= state_d;

      if (start)
        bit_cnt_q <= '0;
      else if (shift_en)
        bit_cnt_q <= bit_last ? '0 : bit_cnt_q + 1'b1;

      // Byte budget
      if (start)
        out_cnt_q <= tx_count_i;
      else if (xfer_dec)
        out_cnt_q <= out_cnt_q - 1'b1;

      // Parallel load wins over shift
      if (start)
        out_q <= status.data;
      else if (load_head)
        out_q <= head_i.data;
      else if (shift_en)
        out_q <= {1'b0, out_q[JSP_BYTE_BITS-1:1]};
    end
  end

  assign tdo_o = out_q[0];  // LSB first

endmodule

// File: hdl/jsp_top.sv
////////////////////////////////////////
// JTAG serial port top, joins both paths to their FIFOs
////////////////////////////////////////
`timescale 1ns/1ps

module jsp_top
  import jsp_pkg::*;
(
  input  logic        tck_i,
  input  logic        rst_i,
  input  logic        tdi_i,
  input  jsp_tap_t    tap_i,       // Decoded TAP state
  output logic        tdo_o,
  output jsp_stream_t rx_o,        // Host bytes to the system
  input  logic        rx_ready_i,
  input  jsp_stream_t tx_i,        // System bytes to the host
  output logic        tx_ready_o
);

  jsp_stream_t rx_push;   // Write path into rx FIFO
  jsp_stream_t tx_head;   // Head of tx FIFO to read path
  logic        tx_pop;
  jsp_count_t  rx_count;
  jsp_count_t  tx_count;

  ////////////////////////////////////////
  // Host to system

  jsp_rx_ctrl u_rx_ctrl (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .tdi_i      (tdi_i),
    .tap_i      (tap_i),
    .rx_count_i (rx_count),
    .push_o     (rx_push)
  );

  // Ready not needed, pushes stay within the sampled space
  jsp_byte_fifo u_rx_fifo (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .wr_i       (rx_push),
    .wr_ready_o (),
    .rd_o       (rx_o),
    .rd_ready_i (rx_ready_i),
    .count_o    (rx_count)
  );

  ////////////////////////////////////////
  // System to host

  jsp_byte_fifo u_tx_fifo (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .wr_i       (tx_i),
    .wr_ready_o (tx_ready_o),
    .rd_o       (tx_head),
    .rd_ready_i (tx_pop),
    .count_o    (tx_count)
  );

  jsp_tx_ctrl u_tx_ctrl (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .tap_i      (tap_i),
    .rx_count_i (rx_count),
    .tx_count_i (tx_count),
    .head_i     (tx_head),
    .pop_o      (tx_pop),
    .tdo_o      (tdo_o)
  );

endmodule

// File: include/jsp_tb_tasks.svh
////////////////////////////////////////
// Bench tasks, included in the testbench module body
// JTAG sessions, random source, reference model and compares
////////////////////////////////////////
`ifndef JSP_TB_TASKS_SVH
`define JSP_TB_TASKS_SVH

////////////////////////////////////////
// Failure handling and compares

task automatic abort_run(input string reason);
  $display("*** FAILED ***");
  $fatal(1, "%s", reason);
endtask

task automatic check_status(input string name, input jsp_word_u exp, input jsp_word_u act);
  if (act !== exp) begin
    $display("** Error at %0t ns: %s expected %h (hi %0d lo %0d), got %h (hi %0d lo %0d)",
             $time, name, exp.data, exp.nib.hi, exp.nib.lo, act.data, act.nib.hi, act.nib.lo);
    abort_run("status byte mismatch");
  end
endtask

task automatic check_byte(input string name, input jsp_byte_t exp, input jsp_byte_t act);
  if (act !== exp) begin
    $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    abort_run("data byte mismatch");
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
    abort_run("flag mismatch");
  end
endtask

////////////////////////////////////////
// Random source

// Galois form with taps for x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic int rand_bits(input int n);
  int v;
  int i;
  v = 0;
  for (i = 0; i < n; i++) begin
    v = (v << 1) | int'(lfsr_q[0]);  // One step per bit taken
    lfsr_q = lfsr_next(lfsr_q);
  end
  return v;
endfunction

////////////////////////////////////////
// Reference model

// Status seen at capture and how many host bytes fit
function automatic jsp_word_u expect_session(input int tx_queued, input int rx_held,
                                             input int n_user, output int n_accept);
  jsp_word_u w;
  int        free_space;
  free_space = JSP_FIFO_DEPTH - rx_held;
  w.nib.hi   = jsp_count_t'(tx_queued);   // Bytes waiting for the host
  w.nib.lo   = jsp_count_t'(free_space);  // Room for host bytes
  n_accept   = (n_user < free_space) ? n_user : free_space;
  return w;
endfunction

////////////////////////////////////////
// Drivers

task automatic drive_tap(input logic cap, input logic sh, input logic upd, input logic sel);
  tap.capture = cap;
  tap.shift   = sh;
  tap.update  = upd;
  tap.select  = sel;
endtask

task automatic fill_wr(input int n);
  int i;
  for (i = 0; i < n; i++) wr_buf[i] = jsp_byte_t'(rand_bits(8));
endtask

// One byte into the tx FIFO once it has room
task automatic push_tx(input jsp_byte_t b);
  @(negedge tck);
  tx.valid = 1'b1;
  tx.data  = b;
  while (!tx_ready) @(negedge tck);  // Ready as the next rising edge sees it
  @(negedge tck);                    // Transfer edge has passed
  model_tx_q.push_back(b);
  tx.valid = 1'b0;
endtask

// Capture, shift start bit + header + n_user bytes, update
task automatic run_session(input int n_user);
  jsp_word_u exp_status;
  jsp_word_u got_status;
  jsp_byte_t got [17];  // Bytes seen on TDO with the status first
  jsp_byte_t hdr;
  jsp_byte_t exp_b;
  int        k;
  int        n_accept;
  int        n_bits;
  int        i;
  int        j;
  k      = model_tx_q.size();
  hdr    = {jsp_count_t'(n_user), 4'h0};  // Low nibble unused
  n_bits = 9 + 8 * n_user;
  if (8 * (k + 1) > n_bits) n_bits = 8 * (k + 1);  // Long enough to read all

  @(negedge tck);
  drive_tap(1'b1, 1'b0, 1'b0, 1'b1);  // Capture-DR
  // Queue sizes as the capture edge sees them
  exp_status = expect_session(k, exp_rx_q.size(), n_user, n_accept);
  for (i = 0; i < n_accept; i++) exp_rx_q.push_back(wr_buf[i]);
  for (i = 0; i < n_bits; i++) begin
    @(negedge tck);
    drive_tap(1'b0, 1'b1, 1'b0, 1'b1);
    if (i == 0) tdi = 1'b1;                 // Start bit
    else if (i < 9) tdi = hdr[i - 1];       // Header LSB first
    else begin
      j   = (i - 9) / 8;                    // Data byte index
      tdi = (j < n_user) ? wr_buf[j][(i - 9) % 8] : 1'b0;
    end
    got[i / 8][i % 8] = tdo;                // Bit before this shift edge
  end
  @(negedge tck);
  drive_tap(1'b0, 1'b0, 1'b1, 1'b1);        // Update-DR
  tdi = 1'b0;
  @(negedge tck);
  drive_tap(1'b0, 1'b0, 1'b0, 1'b0);

  got_status.data = got[0];
  check_status("tdo_o status", exp_status, got_status);
  for (i = 1; i <= k; i++) begin
    exp_b = model_tx_q.pop_front();
    check_byte("tdo_o data", exp_b, got[i]);
  end
endtask

// Let the consumer run until every expected host byte came out
task automatic drain_rx();
  rx_ready = 1'b1;
  while (exp_rx_q.size() != 0) @(negedge tck);
endtask

`endif

// File: bench/jsp_tb.sv
////////////////////////////////////////
// Testbench for the JTAG serial port top
// Runs host sessions in both directions and checks every byte
////////////////////////////////////////
`timescale 1ns/1ps

module jsp_tb
  import jsp_pkg::*;
();

  localparam int CLK_NS           = 4;
  localparam int N_SESSIONS       = 14;
  localparam int BITS_PER_SESSION = 132;   // Longest write plus capture and update
  localparam int MARGIN_NS        = 4000;  // Reset, tx pushes and drains
  localparam int WATCHDOG_NS      = N_SESSIONS * BITS_PER_SESSION * CLK_NS + MARGIN_NS;

  logic        tck = 1'b0;
  logic        rst;
  logic        tdi;
  jsp_tap_t    tap;
  logic        tdo;
  jsp_stream_t rx;        // Host bytes leaving the DUT
  logic        rx_ready;
  jsp_stream_t tx;        // System bytes into the DUT
  logic        tx_ready;

  logic [31:0] lfsr_q = 32'h4d1b_8aac;
  jsp_byte_t   model_tx_q [$];  // Queued in the tx FIFO and not yet read
  jsp_byte_t   exp_rx_q [$];    // Accepted by the write path and not yet seen on rx
  jsp_byte_t   wr_buf [16];     // Payload of the next host write

  `include "jsp_tb_tasks.svh"

  jsp_top i_dut (
    .tck_i      (tck),
    .rst_i      (rst),
    .tdi_i      (tdi),
    .tap_i      (tap),
    .tdo_o      (tdo),
    .rx_o       (rx),
    .rx_ready_i (rx_ready),
    .tx_i       (tx),
    .tx_ready_o (tx_ready)
  );

  always #(CLK_NS / 2) tck = ~tck;

  ////////////////////////////////////////
  // Scoreboard for the rx stream
  always @(posedge tck) begin : rx_scoreboard
    jsp_byte_t exp_b;
    if (!rst && rx.valid && rx_ready) begin
      if (exp_rx_q.size() == 0) begin
        $display("Byte %h came out of rx_o at %0t ns without being sent", rx.data, $time);
        abort_run("unexpected byte on rx_o");
      end else begin
        exp_b = exp_rx_q.pop_front();
        check_byte("rx_o.data", exp_b, rx.data);
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    abort_run("watchdog expired");
  end

  ////////////////////////////////////////
  // Stimulus
  initial begin : stimulus
    int n;
    int i;
    int s;
    rst      = 1'b1;
    tdi      = 1'b0;
    tap      = '0;
    rx_ready = 1'b0;
    tx       = '0;
    repeat (10) @(negedge tck);
    rst = 1'b0;

    check_flag("rx_o.valid", 1'b0, rx.valid);  // Both FIFOs empty
    check_flag("tx_ready_o", 1'b1, tx_ready);
    run_session(0);                            // hi 0, lo 8

    // Two host bytes held, three system bytes queued
    fill_wr(2);
    run_session(2);
    for (i = 0; i < 3; i++) push_tx(jsp_byte_t'(rand_bits(8)));
    run_session(0);  // hi 3, lo 6, then the three bytes
    run_session(0);  // Queue read out so hi is 0
    drain_rx();

    // Plain write with the consumer running
    fill_wr(5);
    run_session(5);
    drain_rx();

    // Overflow with 3 held leaves room for only 5 of 9
    rx_ready = 1'b0;
    fill_wr(3);
    run_session(3);
    fill_wr(9);
    run_session(9);
    for (i = 0; i < JSP_FIFO_DEPTH; i++) push_tx(jsp_byte_t'(rand_bits(8)));
    check_flag("tx_ready_o", 1'b0, tx_ready);  // tx FIFO full
    run_session(0);                            // Reads all 8 with lo at 0
    drain_rx();

    // Mixed traffic
    for (s = 0; s < 6; s++) begin
      rx_ready = rand_bits(1);
      n = rand_bits(3);
      if (n > JSP_FIFO_DEPTH - model_tx_q.size()) n = JSP_FIFO_DEPTH - model_tx_q.size();
      for (i = 0; i < n; i++) push_tx(jsp_byte_t'(rand_bits(8)));
      n = rand_bits(4);
      fill_wr(n);
      run_session(n);
    end
    drain_rx();

    // Every expected byte is out, so the rx FIFO must be empty
    if (rx.valid !== 1'b0) begin
      $display("Byte %h still waits on rx_o after all expected bytes", rx.data);
      abort_run("stray byte on rx_o");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// File: vlog.f
+incdir+include
hdl/jsp_pkg.sv
hdl/jsp_byte_fifo.sv
hdl/jsp_rx_ctrl.sv
hdl/jsp_tx_ctrl.sv
hdl/jsp_top.sv
bench/jsp_tb.sv
